// File: ccu_snoop.f
source/ccu_snoop_pkg.sv
source/snoop_req_arbiter.sv
source/snoop_idx_fifo.sv
source/snoop_port_ctrl.sv
source/ccu_snoop_top.sv
testbench/snoop_cache_model.sv
testbench/tb_ccu_snoop.sv

// File: run_sim.sh
#!/bin/sh
# build and run the ccu_snoop testbench with Verilator

verilator --binary --timing --assert -Wno-fatal --top-module tb_ccu_snoop \
    -f ccu_snoop.f -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "compile step failed"
    exit 1
fi

out=$(./obj_dir/Vtb_ccu_snoop)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "Regression passed"; then
    exit 0
fi
exit 1

// File: testbench/tb_ccu_snoop.sv
`default_nettype none

module tb_ccu_snoop;
    import ccu_snoop_pkg::*;

    localparam int unsigned MaxSnoops      = 50;
    localparam int unsigned CyclesPerSnoop = 40;
    localparam int unsigned MaxCycles      = MaxSnoops * CyclesPerSnoop;
    localparam int unsigned RandSnoops     = 40;

    logic                             clk_i;
    logic                             reset_i;
    logic [NumInp-1:0]                req_ac_valid_i;
    logic [NumInp-1:0][AddrWidth-1:0] req_ac_addr_i;
    snoop_op_e [NumInp-1:0]           req_ac_op_i;
    logic [NumInp-1:0]                req_ac_ready_o;
    logic [NumInp-1:0]                req_cr_valid_o;
    logic [NumInp-1:0]                req_cr_ready_i;
    logic [CrRespWidth-1:0]           req_cr_resp_o;
    logic [NumInp-1:0]                req_cd_valid_o;
    logic [NumInp-1:0]                req_cd_ready_i;
    logic [DataWidth-1:0]             req_cd_data_o;
    logic                             req_cd_last_o;
    logic                             port_ac_valid_o;
    logic                             port_ac_ready_i;
    logic [AddrWidth-1:0]             port_ac_addr_o;
    snoop_op_e                        port_ac_op_o;
    logic                             port_cr_valid_i;
    logic                             port_cr_ready_o;
    logic [CrRespWidth-1:0]           port_cr_resp_i;
    logic                             port_cd_valid_i;
    logic                             port_cd_ready_o;
    logic [DataWidth-1:0]             port_cd_data_i;
    logic                             port_cd_last_i;
    logic                             ac_stall;

    logic [AddrWidth-1:0] send_addr_q [NumInp][$];
    snoop_op_e            send_op_q   [NumInp][$];
    logic [AddrWidth-1:0] exp_addr_q  [NumInp][$];
    logic [AddrWidth+1:0] port_seen_q [$];
    logic                 in_data  [NumInp];
    int unsigned          beat_cnt [NumInp];
    int unsigned          errors;
    int unsigned          cycles;
    logic [15:0]          lfsr_state;

    ccu_snoop_top u_ccu_snoop_top (.*);

    snoop_cache_model u_cache (
        .clk_i,
        .reset_i,
        .ac_stall_i (ac_stall),
        .ac_valid_i (port_ac_valid_o),
        .ac_ready_o (port_ac_ready_i),
        .ac_addr_i  (port_ac_addr_o),
        .cr_valid_o (port_cr_valid_i),
        .cr_ready_i (port_cr_ready_o),
        .cr_resp_o  (port_cr_resp_i),
        .cd_valid_o (port_cd_valid_i),
        .cd_ready_i (port_cd_ready_o),
        .cd_data_o  (port_cd_data_i),
        .cd_last_o  (port_cd_last_i)
    );

    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;
    end

    // taps 16 14 13 11, one step per bit taken
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [31:0] take_bits(input int unsigned n);
        logic [31:0] v;
        v = '0;
        for (int unsigned k = 0; k < n; k++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic int unsigned outstanding();
        int unsigned n;
        n = 0;
        for (int i = 0; i < NumInp; i++) begin
            n += exp_addr_q[i].size();
        end
        return n;
    endfunction

    task automatic compare_value(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        assert (expected == actual)
        else begin
            errors++;
            $display("[FAIL] %0t %s expected %0h got %0h", $time, name, expected, actual);
        end
    endtask

    // the scoreboard entry is queued with the request, in per-input order
    task automatic issue_snoop(input int unsigned idx, input logic [AddrWidth-1:0] addr,
                               input snoop_op_e op);
        send_addr_q[idx].push_back(addr);
        send_op_q[idx].push_back(op);
        exp_addr_q[idx].push_back(addr);
    endtask

    task automatic take_cr(input int i);
        logic [CrRespWidth-1:0] exp_resp;
        logic [AddrWidth-1:0]   addr;
        assert (exp_addr_q[i].size() != 0 && !in_data[i])
        else begin
            errors++;
            $display("%0t: input %0d received a CR it was not waiting for", $time, i);
        end
        if (exp_addr_q[i].size() != 0 && !in_data[i]) begin
            addr = exp_addr_q[i][0];
            exp_resp = '0;
            exp_resp[CrDataTransferBit] = addr[4];
            compare_value($sformatf("req_cr_resp_o[%0d]", i), 32'(exp_resp), 32'(req_cr_resp_o));
            in_data[i]  = addr[4];
            beat_cnt[i] = 0;
            if (!addr[4]) begin
                exp_addr_q[i].delete(0);
            end
        end
    endtask

    task automatic take_cd(input int i);
        logic [AddrWidth-1:0] addr;
        logic                 last;
        assert (in_data[i])
        else begin
            errors++;
            $display("%0t: input %0d received a CD beat with no data owed", $time, i);
        end
        if (in_data[i]) begin
            addr = exp_addr_q[i][0];
            last = (beat_cnt[i] == 32'(addr[1:0]));
            compare_value($sformatf("req_cd_data_o[%0d]", i), addr + beat_cnt[i], req_cd_data_o);
            compare_value($sformatf("req_cd_last_o[%0d]", i), 32'(last), 32'(req_cd_last_o));
            beat_cnt[i]++;
            if (last) begin
                in_data[i] = 1'b0;
                exp_addr_q[i].delete(0);
            end
        end
    endtask

    // each requester keeps its head request up until it is accepted
    always @(posedge clk_i) begin
        for (int i = 0; i < NumInp; i++) begin
            if (req_ac_valid_i[i] && req_ac_ready_o[i]) begin
                send_addr_q[i].delete(0);
                send_op_q[i].delete(0);
            end
            req_ac_valid_i[i] <= (send_addr_q[i].size() != 0);
            if (send_addr_q[i].size() != 0) begin
                req_ac_addr_i[i] <= send_addr_q[i][0];
                req_ac_op_i[i]   <= send_op_q[i][0];
            end
        end
    end

    always @(posedge clk_i) begin
        if (!reset_i) begin
            for (int i = 0; i < NumInp; i++) begin
                if (req_cr_valid_o[i] && req_cr_ready_i[i]) begin
                    take_cr(i);
                end
                if (req_cd_valid_o[i] && req_cd_ready_i[i]) begin
                    take_cd(i);
                end
            end
            if (port_ac_valid_o && port_ac_ready_i) begin
                port_seen_q.push_back({port_ac_op_o, port_ac_addr_o});
            end
        end
    end

    task automatic apply_reset();
        @(posedge clk_i);
        reset_i <= 1'b1;
        repeat (5) @(posedge clk_i);
        reset_i <= 1'b0;
        @(negedge clk_i);
    endtask

    task automatic clear_stats();
        port_seen_q.delete();
        for (int i = 0; i < NumInp; i++) begin
            in_data[i]  = 1'b0;
            beat_cnt[i] = 0;
        end
    endtask

    task automatic wait_drain();
        while (outstanding() != 0) begin
            @(negedge clk_i);
        end
        repeat (2) @(negedge clk_i);
    endtask

    task automatic single_snoop_no_data();
        clear_stats();
        issue_snoop(2, 32'h0000_1204, CleanInvalid);
        wait_drain();
        compare_value("port_ac_valid_o count", 1, port_seen_q.size());
        compare_value("port_ac_addr_o", 32'h0000_1204, port_seen_q[0][AddrWidth-1:0]);
        compare_value("port_ac_op_o", 32'(CleanInvalid), 32'(port_seen_q[0][AddrWidth+1:AddrWidth]));
    endtask

    task automatic snoop_with_data();
        clear_stats();
        issue_snoop(1, 32'h0000_2013, ReadUnique); // four beats
        wait_drain();
    endtask

    task automatic four_inputs_at_once();
        logic [AddrWidth-1:0] addr [NumInp];
        apply_reset();
        clear_stats();
        for (int i = 0; i < NumInp; i++) begin
            addr[i] = 32'h0000_3010 + 32'(i) * 32'h0000_0101; // input i gets i+1 beats
            issue_snoop(i, addr[i], snoop_op_e'(i));
        end
        wait_drain();
        for (int i = 0; i < NumInp; i++) begin
            compare_value($sformatf("port_ac_addr_o #%0d", i), addr[i],
                          port_seen_q[i][AddrWidth-1:0]);
        end
    endtask

    task automatic back_pressure();
        clear_stats();
        @(posedge clk_i);
        ac_stall <= 1'b1;
        @(negedge clk_i);
        issue_snoop(3, 32'h0000_4000, ReadShared);
        repeat (10) @(negedge clk_i);
        assert (send_addr_q[3].size() == 1)
        else begin
            errors++;
            $display("%0t: a request got through while the port held ready low", $time);
        end
        @(posedge clk_i);
        ac_stall <= 1'b0;
        wait_drain();
        @(posedge clk_i);
        req_cr_ready_i[0] <= 1'b0;
        req_cd_ready_i[0] <= 1'b0;
        @(negedge clk_i);
        issue_snoop(0, 32'h0000_4011, ReadUnique); // two beats
        issue_snoop(0, 32'h0000_4020, MakeInvalid);
        repeat (20) @(negedge clk_i);
        compare_value("req_cr_valid_o[0]", 1, req_cr_valid_o[0]);
        compare_value("port_cr_ready_o", 0, port_cr_ready_o);
        @(posedge clk_i);
        req_cr_ready_i[0] <= 1'b1;
        repeat (5) @(negedge clk_i);
        compare_value("req_cd_valid_o[0]", 1, req_cd_valid_o[0]);
        compare_value("port_cd_ready_o", 0, port_cd_ready_o);
        @(posedge clk_i);
        req_cd_ready_i[0] <= 1'b1;
        wait_drain();
    endtask

    task automatic random_snoops();
        int unsigned          issued;
        logic [IdxWidth-1:0]  idx;
        logic [AddrWidth-1:0] addr;
        snoop_op_e            op;
        issued = 0;
        clear_stats();
        while (issued < RandSnoops || outstanding() != 0) begin
            @(posedge clk_i);
            req_cr_ready_i <= NumInp'(take_bits(NumInp));
            req_cd_ready_i <= NumInp'(take_bits(NumInp));
            @(negedge clk_i);
            if (issued < RandSnoops && take_bits(1) == 1) begin
                idx  = IdxWidth'(take_bits(IdxWidth));
                addr = take_bits(AddrWidth);
                op   = snoop_op_e'(take_bits(2));
                issue_snoop(idx, addr, op);
                issued++;
            end
        end
        @(posedge clk_i);
        req_cr_ready_i <= '1;
        req_cd_ready_i <= '1;
        wait_drain();
        compare_value("port_ac_valid_o count", RandSnoops, port_seen_q.size());
    endtask

    initial begin
        reset_i        = 1'b1;
        req_ac_valid_i = '0;
        req_ac_addr_i  = '0;
        for (int i = 0; i < NumInp; i++) begin
            req_ac_op_i[i] = ReadShared;
        end
        req_cr_ready_i = '1;
        req_cd_ready_i = '1;
        ac_stall       = 1'b0;
        errors         = 0;
        lfsr_state     = 16'd38;
        clear_stats();
        apply_reset();
        single_snoop_no_data();
        snoop_with_data();
        four_inputs_at_once();
        back_pressure();
        random_snoops();
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    initial begin
        cycles = 0;
        while (cycles < MaxCycles) begin
            @(posedge clk_i);
            cycles++;
        end
        $display("timeout: tests still running after %0d cycles", MaxCycles);
        $display("errors: %0d", errors);
        $display("Regression failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: testbench/snoop_cache_model.sv
`default_nettype none

module snoop_cache_model (
    input  wire logic                                  clk_i,
    input  wire logic                                  reset_i,
    input  wire logic                                  ac_stall_i,
    input  wire logic                                  ac_valid_i,
    output logic                                       ac_ready_o,
    input  wire logic [ccu_snoop_pkg::AddrWidth-1:0]   ac_addr_i,
    output logic                                       cr_valid_o,
    input  wire logic                                  cr_ready_i,
    output logic      [ccu_snoop_pkg::CrRespWidth-1:0] cr_resp_o,
    output logic                                       cd_valid_o,
    input  wire logic                                  cd_ready_i,
    output logic      [ccu_snoop_pkg::DataWidth-1:0]   cd_data_o,
    output logic                                       cd_last_o
);
    import ccu_snoop_pkg::*;

    logic [AddrWidth-1:0] pend_q [$];
    logic [AddrWidth-1:0] cur_addr;
    logic [AddrWidth-1:0] next_addr;
    logic [1:0]           beat;

    assign ac_ready_o = !ac_stall_i;

    initial begin
        cr_valid_o = 1'b0;
        cr_resp_o  = '0;
        cd_valid_o = 1'b0;
        cd_data_o  = '0;
        cd_last_o  = 1'b0;
    end

    // requests are answered strictly in arrival order, one at a time
    always @(posedge clk_i) begin
        if (reset_i) begin
            pend_q.delete();
            cr_valid_o <= 1'b0;
            cd_valid_o <= 1'b0;
            cd_last_o  <= 1'b0;
        end else begin
            if (ac_valid_i && ac_ready_o) begin
                pend_q.push_back(ac_addr_i);
            end
            if (cr_valid_o && cr_ready_i) begin
                cr_valid_o <= 1'b0;
                if (cur_addr[4]) begin // address bit 4 asks for data beats
                    cd_valid_o <= 1'b1;
                    cd_data_o  <= cur_addr;
                    cd_last_o  <= (cur_addr[1:0] == 2'd0);
                    beat       <= 2'd0;
                end
            end else if (cd_valid_o && cd_ready_i) begin
                if (cd_last_o) begin
                    cd_valid_o <= 1'b0;
                end else begin
                    beat      <= beat + 2'd1;
                    cd_data_o <= cur_addr + DataWidth'(beat) + DataWidth'(1);
                    cd_last_o <= (beat + 2'd1 == cur_addr[1:0]);
                end
            end else if (!cr_valid_o && !cd_valid_o && pend_q.size() != 0) begin
                next_addr  = pend_q.pop_front();
                cur_addr   <= next_addr;
                cr_valid_o <= 1'b1;
                cr_resp_o  <= CrRespWidth'(next_addr[4]) << CrDataTransferBit;
            end
        end
    end

endmodule

`default_nettype wire

// File: source/ccu_snoop_top.sv
`default_nettype none

module ccu_snoop_top (
    input  wire logic                                                          clk_i,
    input  wire logic                                                          reset_i,

    input  wire logic [ccu_snoop_pkg::NumInp-1:0]                              req_ac_valid_i,
    input  wire logic [ccu_snoop_pkg::NumInp-1:0][ccu_snoop_pkg::AddrWidth-1:0] req_ac_addr_i,
    input  wire ccu_snoop_pkg::snoop_op_e [ccu_snoop_pkg::NumInp-1:0]          req_ac_op_i,
    output logic      [ccu_snoop_pkg::NumInp-1:0]                              req_ac_ready_o,

    output logic      [ccu_snoop_pkg::NumInp-1:0]                              req_cr_valid_o,
    input  wire logic [ccu_snoop_pkg::NumInp-1:0]                              req_cr_ready_i,
    output logic      [ccu_snoop_pkg::CrRespWidth-1:0]                         req_cr_resp_o,

    output logic      [ccu_snoop_pkg::NumInp-1:0]                              req_cd_valid_o,
    input  wire logic [ccu_snoop_pkg::NumInp-1:0]                              req_cd_ready_i,
    output logic      [ccu_snoop_pkg::DataWidth-1:0]                           req_cd_data_o,
    output logic                                                               req_cd_last_o,

    output logic                                                               port_ac_valid_o,
    input  wire logic                                                          port_ac_ready_i,
    output logic      [ccu_snoop_pkg::AddrWidth-1:0]                           port_ac_addr_o,
    output ccu_snoop_pkg::snoop_op_e                                           port_ac_op_o,

    input  wire logic                                                          port_cr_valid_i,
    output logic                                                               port_cr_ready_o,
    input  wire logic [ccu_snoop_pkg::CrRespWidth-1:0]                         port_cr_resp_i,

    input  wire logic                                                          port_cd_valid_i,
    output logic                                                               port_cd_ready_o,
    input  wire logic [ccu_snoop_pkg::DataWidth-1:0]                           port_cd_data_i,
    input  wire logic                                                          port_cd_last_i
);
    import ccu_snoop_pkg::*;

    logic                 arb_valid;
    logic                 arb_ready;
    logic [IdxWidth-1:0]  arb_idx;
    logic [AddrWidth-1:0] arb_addr;
    snoop_op_e            arb_op;

    snoop_req_arbiter u_arbiter (
        .clk_i,
        .reset_i,
        .req_valid_i (req_ac_valid_i),
        .req_ready_o (req_ac_ready_o),
        .req_addr_i  (req_ac_addr_i),
        .req_op_i    (req_ac_op_i),
        .arb_valid_o (arb_valid),
        .arb_ready_i (arb_ready),
        .arb_idx_o   (arb_idx),
        .arb_addr_o  (arb_addr),
        .arb_op_o    (arb_op)
    );

    snoop_port_ctrl u_port_ctrl (
        .clk_i,
        .reset_i,
        .inp_ac_valid_i (arb_valid),
        .inp_ac_ready_o (arb_ready),
        .inp_idx_i      (arb_idx),
        .inp_cr_valid_o (req_cr_valid_o),
        .inp_cr_ready_i (req_cr_ready_i),
        .inp_cd_valid_o (req_cd_valid_o),
        .inp_cd_ready_i (req_cd_ready_i),
        .oup_ac_valid_o (port_ac_valid_o),
        .oup_ac_ready_i (port_ac_ready_i),
        .oup_cr_valid_i (port_cr_valid_i),
        .oup_cr_ready_o (port_cr_ready_o),
        .oup_cr_resp_i  (port_cr_resp_i),
        .oup_cd_valid_i (port_cd_valid_i),
        .oup_cd_ready_o (port_cd_ready_o),
        .oup_cd_last_i  (port_cd_last_i)
    );

    // request payload passes straight through, the controller only handles handshakes
    assign port_ac_addr_o = arb_addr;
    assign port_ac_op_o   = arb_op;

    // response payloads go to every requester, the valid bits pick the receiver
    assign req_cr_resp_o = port_cr_resp_i;
    assign req_cd_data_o = port_cd_data_i;
    assign req_cd_last_o = port_cd_last_i;

endmodule

`default_nettype wire

// File: source/snoop_port_ctrl.sv
`default_nettype none

module snoop_port_ctrl (
    input  wire logic                                  clk_i,
    input  wire logic                                  reset_i,

    input  wire logic                                  inp_ac_valid_i,
    output logic                                       inp_ac_ready_o,
    input  wire logic [ccu_snoop_pkg::IdxWidth-1:0]    inp_idx_i,

    output logic      [ccu_snoop_pkg::NumInp-1:0]      inp_cr_valid_o,
    input  wire logic [ccu_snoop_pkg::NumInp-1:0]      inp_cr_ready_i,
    output logic      [ccu_snoop_pkg::NumInp-1:0]      inp_cd_valid_o,
    input  wire logic [ccu_snoop_pkg::NumInp-1:0]      inp_cd_ready_i,

    output logic                                       oup_ac_valid_o,
    input  wire logic                                  oup_ac_ready_i,
    input  wire logic                                  oup_cr_valid_i,
    output logic                                       oup_cr_ready_o,
    input  wire logic [ccu_snoop_pkg::CrRespWidth-1:0] oup_cr_resp_i,
    input  wire logic                                  oup_cd_valid_i,
    output logic                                       oup_cd_ready_o,
    input  wire logic                                  oup_cd_last_i
);
    import ccu_snoop_pkg::*;

    logic                ac_taken_q;
    logic                idx_taken_q;
    logic                ac_done;
    logic                idx_done;
    logic                idx_push_valid;
    logic                idx_push_ready;
    logic                head_valid;
    logic                head_pop;
    logic [IdxWidth-1:0] head_idx;
    logic                cr_has_data;
    logic                cr_open;
    logic                cr_fire;
    logic                data_pending_q;
    logic                cd_fire;

    // fork of the request to the port and the index FIFO
    assign oup_ac_valid_o = inp_ac_valid_i && !ac_taken_q;
    assign idx_push_valid = inp_ac_valid_i && !idx_taken_q;
    assign ac_done        = ac_taken_q || oup_ac_ready_i;
    assign idx_done       = idx_taken_q || idx_push_ready;
    assign inp_ac_ready_o = ac_done && idx_done;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            ac_taken_q  <= 1'b0;
            idx_taken_q <= 1'b0;
        end else if (inp_ac_valid_i && !inp_ac_ready_o) begin
            ac_taken_q  <= ac_done; // one side took it, wait for the other
            idx_taken_q <= idx_done;
        end else begin
            ac_taken_q  <= 1'b0;
            idx_taken_q <= 1'b0;
        end
    end

    snoop_idx_fifo u_idx_fifo (
        .clk_i,
        .reset_i,
        .push_valid_i (idx_push_valid),
        .push_ready_o (idx_push_ready),
        .push_idx_i   (inp_idx_i),
        .pop_valid_o  (head_valid),
        .pop_ready_i  (head_pop),
        .pop_idx_o    (head_idx)
    );

    // while data is still owed the head belongs to that transfer
    assign cr_has_data = oup_cr_resp_i[CrDataTransferBit];
    assign cr_open     = head_valid && !data_pending_q;

    always_comb begin
        inp_cr_valid_o           = '0;
        inp_cr_valid_o[head_idx] = oup_cr_valid_i && cr_open;
    end

    assign oup_cr_ready_o = cr_open && inp_cr_ready_i[head_idx];
    assign cr_fire        = oup_cr_valid_i && oup_cr_ready_o;

    // CD joins the port beat with the data grant left by the CR
    always_comb begin
        inp_cd_valid_o           = '0;
        inp_cd_valid_o[head_idx] = oup_cd_valid_i && data_pending_q;
    end

    assign oup_cd_ready_o = data_pending_q && inp_cd_ready_i[head_idx];
    assign cd_fire        = oup_cd_valid_i && oup_cd_ready_o;

    assign head_pop = (cr_fire && !cr_has_data) || (cd_fire && oup_cd_last_i);

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            data_pending_q <= 1'b0;
        end else if (cr_fire && cr_has_data) begin
            data_pending_q <= 1'b1;
        end else if (cd_fire && oup_cd_last_i) begin
            data_pending_q <= 1'b0;
        end
    end

    // CR and CD are never offered together, and each goes to one input only
    a_valid_onehot: assert property (@(posedge clk_i) disable iff (reset_i)
        $onehot0({inp_cr_valid_o, inp_cd_valid_o}))
        else $error("response routed to more than one input");

    a_cd_pending: assert property (@(posedge clk_i) disable iff (reset_i)
        cd_fire |-> data_pending_q && head_valid)
        else $error("CD beat transferred without a pending data response");

endmodule

`default_nettype wire

// File: source/snoop_idx_fifo.sv
`default_nettype none

module snoop_idx_fifo (
    input  wire logic                                clk_i,
    input  wire logic                                reset_i,

    input  wire logic                                push_valid_i,
    output logic                                     push_ready_o,
    input  wire logic [ccu_snoop_pkg::IdxWidth-1:0]  push_idx_i,

    output logic                                     pop_valid_o,
    input  wire logic                                pop_ready_i,
    output logic      [ccu_snoop_pkg::IdxWidth-1:0]  pop_idx_o
);
    import ccu_snoop_pkg::*;

    logic [IdxWidth-1:0]    mem_q [IdxFifoDepth];
    logic [IdxPtrWidth-1:0] wr_ptr_q;
    logic [IdxPtrWidth-1:0] rd_ptr_q;
    logic [IdxCntWidth-1:0] count_q;
    logic                   push_fire;
    logic                   pop_fire;

    assign push_ready_o = (count_q != IdxCntWidth'(IdxFifoDepth));
    assign pop_valid_o  = (count_q != '0);
    assign pop_idx_o    = mem_q[rd_ptr_q]; // head comes from a register only
    assign push_fire    = push_valid_i && push_ready_o;
    assign pop_fire     = pop_valid_o && pop_ready_i;

    always_ff @(posedge clk_i) begin
        if (push_fire) begin
            mem_q[wr_ptr_q] <= push_idx_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push_fire) begin
                wr_ptr_q <= (wr_ptr_q == IdxPtrWidth'(IdxFifoDepth - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop_fire) begin
                rd_ptr_q <= (rd_ptr_q == IdxPtrWidth'(IdxFifoDepth - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            case ({push_fire, pop_fire})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    // a write onto the read slot while entries are held would overwrite the head
    a_no_push_full: assert property (@(posedge clk_i) disable iff (reset_i)
        push_fire |-> !((wr_ptr_q == rd_ptr_q) && (count_q != '0)))
        else $error("index pushed into a full FIFO");

    // the controller only releases a head it has already routed to
    a_no_pop_empty: assert property (@(posedge clk_i) disable iff (reset_i)
        pop_ready_i |-> pop_valid_o)
        else $error("index popped from an empty FIFO");

endmodule

`default_nettype wire

// File: source/snoop_req_arbiter.sv
`default_nettype none

module snoop_req_arbiter (
    input  wire logic                                                          clk_i,
    input  wire logic                                                          reset_i,

    input  wire logic [ccu_snoop_pkg::NumInp-1:0]                              req_valid_i,
    output logic      [ccu_snoop_pkg::NumInp-1:0]                              req_ready_o,
    input  wire logic [ccu_snoop_pkg::NumInp-1:0][ccu_snoop_pkg::AddrWidth-1:0] req_addr_i,
    input  wire ccu_snoop_pkg::snoop_op_e [ccu_snoop_pkg::NumInp-1:0]          req_op_i,

    output logic                                                               arb_valid_o,
    input  wire logic                                                          arb_ready_i,
    output logic      [ccu_snoop_pkg::IdxWidth-1:0]                            arb_idx_o,
    output logic      [ccu_snoop_pkg::AddrWidth-1:0]                           arb_addr_o,
    output ccu_snoop_pkg::snoop_op_e                                           arb_op_o
);
    import ccu_snoop_pkg::*;

    logic [IdxWidth-1:0] rr_ptr_q;
    logic                lock_q;
    logic [IdxWidth-1:0] lock_idx_q;
    logic [IdxWidth-1:0] scan_idx;
    logic [IdxWidth-1:0] pick_idx;
    logic                pick_found;
    logic                arb_fire;

    // search upward from the pointer, the index width makes it wrap around
    always_comb begin
        pick_found = 1'b0;
        pick_idx   = rr_ptr_q;
        scan_idx   = rr_ptr_q;
        for (int unsigned i = 0; i < NumInp; i++) begin
            scan_idx = rr_ptr_q + IdxWidth'(i);
            if (!pick_found && req_valid_i[scan_idx]) begin
                pick_found = 1'b1;
                pick_idx   = scan_idx;
            end
        end
    end

    // a stalled grant is pinned so that a late requester cannot steal it mid fork
    assign arb_idx_o   = lock_q ? lock_idx_q : pick_idx;
    assign arb_valid_o = lock_q ? req_valid_i[lock_idx_q] : pick_found;
    assign arb_addr_o  = req_addr_i[arb_idx_o];
    assign arb_op_o    = req_op_i[arb_idx_o];
    assign arb_fire    = arb_valid_o && arb_ready_i;

    always_comb begin
        req_ready_o            = '0;
        req_ready_o[arb_idx_o] = arb_fire;
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            rr_ptr_q   <= '0;
            lock_q     <= 1'b0;
            lock_idx_q <= '0;
        end else begin
            if (arb_fire) begin
                rr_ptr_q <= arb_idx_o + 1'b1; // winner gets lowest priority next
            end
            lock_q     <= arb_valid_o && !arb_ready_i;
            lock_idx_q <= arb_idx_o;
        end
    end

    a_ready_onehot: assert property (@(posedge clk_i) disable iff (reset_i)
        $onehot0(req_ready_o))
        else $error("more than one requester accepted in a cycle");

    // the requester must also keep its valid up while it waits
    a_grant_stable: assert property (@(posedge clk_i) disable iff (reset_i)
        arb_valid_o && !arb_ready_i |=> arb_valid_o && (arb_idx_o == $past(arb_idx_o)))
        else $error("grant moved away from a pending request");

endmodule

`default_nettype wire

// File: source/ccu_snoop_pkg.sv
`default_nettype none

package ccu_snoop_pkg;

    localparam int unsigned NumInp       = 4;
    localparam int unsigned IdxWidth     = 2;
    localparam int unsigned IdxFifoDepth = 2;
    localparam int unsigned IdxPtrWidth  = $clog2(IdxFifoDepth);
    localparam int unsigned IdxCntWidth  = $clog2(IdxFifoDepth + 1);

    localparam int unsigned AddrWidth = 32;
    localparam int unsigned DataWidth = 32;

    // CR response layout, only the data transfer flag is looked at here
    localparam int unsigned CrRespWidth       = 5;
    localparam int unsigned CrDataTransferBit = 0;

    typedef enum logic [1:0] {
        ReadShared   = 2'd0,
        ReadUnique   = 2'd1,
        CleanInvalid = 2'd2,
        MakeInvalid  = 2'd3
    } snoop_op_e;

endpackage

`default_nettype wire
